// File: Bender.yml
package:
  name: cpu_ctrl

export_include_dirs:
  - logic

sources:
  - logic/cpuCtrlPkg.sv
  - logic/instrDecode.sv
  - logic/stepSequencer.sv
  - logic/excTracker.sv
  - logic/cpuCtrlTop.sv
  - target: simulation
    files:
      - sim/cpuCtrl_chk.sv
      - sim/cpuCtrlTb.sv

// File: flist.f
+incdir+logic
logic/cpuCtrlPkg.sv
logic/instrDecode.sv
logic/stepSequencer.sv
logic/excTracker.sv
logic/cpuCtrlTop.sv
sim/cpuCtrl_chk.sv
sim/cpuCtrlTb.sv

// File: logic/cpuCtrlPkg.sv
`default_nettype none

package cpuCtrlPkg;

  typedef enum logic [2:0] {
    clsAluReg,
    clsAluImm,
    clsBranch,
    clsJump,
    clsInvalid
  } instrClass_e;

  typedef enum logic [3:0] {
    aluPassA = 4'd0,
    aluAdd   = 4'd1,
    aluSub   = 4'd2,
    aluAnd   = 4'd3,
    aluSlt   = 4'd10,
    aluBeq   = 4'd11,
    aluBne   = 4'd12,
    aluBle   = 4'd13,
    aluBgt   = 4'd14
  } aluOp_e;

  typedef enum logic [2:0] {
    pcAluResult  = 3'b000,
    pcAluOut     = 3'b001,
    pcJumpTarget = 3'b010,
    pcExcVector  = 3'b100
  } pcSrc_e;

  typedef enum logic {
    excBadOpcode = 1'b0,
    excOverflow  = 1'b1
  } excCause_e;

  typedef enum logic [1:0] {dstRt = 2'b00, dstRd = 2'b01} regDst_e;
  typedef enum logic [1:0] {srcPc = 2'b00, srcRegA = 2'b01} aluSrcA_e;
  typedef enum logic [1:0] {srcRegB, srcFour, srcImm, srcImmShift} aluSrcB_e;

  // Sequencer phases
  typedef enum logic [2:0] {phReset, phFetch, phExec, phExc, phSettle} phase_e;

  typedef struct packed {
    instrClass_e instrClass;
    aluOp_e      aluOp;
    logic        immOp;      // Second operand is the immediate
    logic        ignoreOvf;  // Set for addiu only
    logic        readTwo;    // Both rs and rt are read
  } decodeInfo_t;

  typedef struct packed {
    logic      pcWrite;
    logic      epcWrite;
    logic      irWrite;
    logic      aluOutWrite;
    logic      regAWrite;
    logic      regBWrite;
    logic      regWrite;
    regDst_e   regDstSel;
    aluSrcA_e  aluSrcA;
    aluSrcB_e  aluSrcB;
    aluOp_e    aluOp;
    pcSrc_e    pcSrc;
    excCause_e excCause;
  } controlWord_t;

endpackage

`default_nettype wire

// File: logic/cpuCtrlTop.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCtrlTop import cpuCtrlPkg::*; (
  input  logic         clk,
  input  logic         reset_in,
  input  logic [5:0]   opcode,
  input  logic [5:0]   funct,
  input  logic         branchCond,
  input  logic         overflow,
  output controlWord_t ctrl
);

  decodeInfo_t info;
  logic decodeStrobe;
  logic excTaken;
  logic excPending;
  excCause_e excCause;

  instrDecode uDecode (
    .opcode (opcode),
    .funct  (funct),
    .info   (info)
  );

  stepSequencer uSequencer (
    .clk          (clk),
    .reset_in     (reset_in),
    .info         (info),
    .branchCond   (branchCond),
    .excPending   (excPending),
    .excCause     (excCause),
    .decodeStrobe (decodeStrobe),
    .excTaken     (excTaken),
    .ctrl         (ctrl)
  );

  excTracker uExcTracker (
    .clk          (clk),
    .reset_in     (reset_in),
    .info         (info),
    .decodeStrobe (decodeStrobe),
    .overflow     (overflow),
    .excTaken     (excTaken),
    .excPending   (excPending),
    .excCause     (excCause)
  );

endmodule

`default_nettype wire

// File: logic/cpuCtrl_macros.svh
`ifndef CPU_CTRL_MACROS_SVH
`define CPU_CTRL_MACROS_SVH

// Opcode field
`define OP_RTYPE 6'h00
`define OP_J     6'h02
`define OP_BEQ   6'h04
`define OP_BNE   6'h05
`define OP_BLE   6'h06
`define OP_BGT   6'h07
`define OP_ADDI  6'h08
`define OP_ADDIU 6'h09
`define OP_SLTI  6'h0A

// Funct field of R-type
`define FN_ADD 6'h20
`define FN_SUB 6'h22
`define FN_AND 6'h24
`define FN_SLT 6'h2A

// Cycles spent in each sequence
`define FETCH_STEPS        5
`define ALU_STEPS          5
`define BRANCH_TAKEN_STEPS 8
`define EXC_STEPS          5
`define SETTLE_STEPS       2

`define STEP_WIDTH 4

`endif

// File: logic/excTracker.sv
`timescale 1ns/1ps
`default_nettype none

module excTracker import cpuCtrlPkg::*; (
  input  logic        clk,
  input  logic        reset_in,
  input  decodeInfo_t info,
  input  logic        decodeStrobe,
  input  logic        overflow,
  input  logic        excTaken,
  output logic        excPending,
  output excCause_e   excCause
);

  logic badOpQ;
  logic ovfQ;
  logic ignoreOvfQ;
  logic ignoreOvf;

  // New mask applies already in the decode cycle
  assign ignoreOvf = decodeStrobe ? info.ignoreOvf : ignoreOvfQ;

  always_ff @(posedge clk) begin
    if (reset_in) begin
      badOpQ <= 1'b0;
      ovfQ <= 1'b0;
      ignoreOvfQ <= 1'b0;
    end else if (excTaken) begin
      badOpQ <= 1'b0;
      ovfQ <= 1'b0;
      ignoreOvfQ <= 1'b0;
    end else begin
      if (decodeStrobe) begin
        if (info.instrClass == clsInvalid) badOpQ <= 1'b1;
        ignoreOvfQ <= info.ignoreOvf;
      end
      if (overflow && !ignoreOvf) ovfQ <= 1'b1;  // Sticky until taken
    end
  end

  assign excPending = badOpQ | ovfQ;
  assign excCause = badOpQ ? excBadOpcode : excOverflow;  // Bad opcode has priority

endmodule

`default_nettype wire

// File: logic/instrDecode.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpuCtrl_macros.svh"

module instrDecode import cpuCtrlPkg::*; (
  input  logic [5:0]  opcode,
  input  logic [5:0]  funct,
  output decodeInfo_t info
);

  always_comb begin
    info.instrClass = clsInvalid;  // Anything not matched below
    info.aluOp = aluPassA;
    info.immOp = 1'b0;
    info.ignoreOvf = 1'b0;
    info.readTwo = 1'b0;
    case (opcode)
      `OP_RTYPE: begin
        info.instrClass = clsAluReg;
        info.readTwo = 1'b1;
        case (funct)
          `FN_ADD: info.aluOp = aluAdd;
          `FN_SUB: info.aluOp = aluSub;
          `FN_AND: info.aluOp = aluAnd;
          `FN_SLT: info.aluOp = aluSlt;
          default: begin
            info.instrClass = clsInvalid;  // Unknown funct
            info.readTwo = 1'b0;
          end
        endcase
      end
      `OP_ADDI, `OP_ADDIU: begin
        info.instrClass = clsAluImm;
        info.aluOp = aluAdd;
        info.immOp = 1'b1;
        info.ignoreOvf = (opcode == `OP_ADDIU);  // Unsigned add never traps
      end
      `OP_SLTI: begin
        info.instrClass = clsAluImm;
        info.aluOp = aluSlt;
        info.immOp = 1'b1;
      end
      `OP_BEQ, `OP_BNE, `OP_BLE, `OP_BGT: begin
        info.instrClass = clsBranch;
        info.readTwo = 1'b1;
        case (opcode)
          `OP_BEQ: info.aluOp = aluBeq;
          `OP_BNE: info.aluOp = aluBne;
          `OP_BLE: info.aluOp = aluBle;
          default: info.aluOp = aluBgt;
        endcase
      end
      `OP_J: begin
        info.instrClass = clsJump;  // Taken during decode
      end
      default: begin
        info.instrClass = clsInvalid;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: logic/stepSequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpuCtrl_macros.svh"

module stepSequencer import cpuCtrlPkg::*; (
  input  logic         clk,
  input  logic         reset_in,
  input  decodeInfo_t  info,
  input  logic         branchCond,
  input  logic         excPending,
  input  excCause_e    excCause,
  output logic         decodeStrobe,
  output logic         excTaken,
  output controlWord_t ctrl
);

  localparam logic [`STEP_WIDTH-1:0] branchTestStep = 3;  // Compare result sampled
  localparam logic [`STEP_WIDTH-1:0] branchPcStep = 5;

  phase_e phaseQ;
  phase_e phaseD;
  phase_e curPhase;
  logic [`STEP_WIDTH-1:0] stepQ;
  logic [`STEP_WIDTH-1:0] stepD;
  decodeInfo_t infoQ;
  excCause_e causeQ;
  logic branchTaken;

  // A pending exception replaces the first fetch cycle
  assign curPhase = (phaseQ == phFetch && stepQ == '0 && excPending) ? phExc : phaseQ;
  assign branchTaken = (stepQ > branchTestStep) || (stepQ == branchTestStep && branchCond);

  always_ff @(posedge clk) begin
    if (reset_in) begin
      phaseQ <= phReset;
      stepQ <= '0;
      causeQ <= excBadOpcode;
    end else begin
      phaseQ <= phaseD;
      stepQ <= stepD;
      if (excTaken) causeQ <= excCause;  // Held for the vector write
    end
  end

  always_ff @(posedge clk) begin
    if (decodeStrobe) infoQ <= info;
  end

  always_comb begin
    ctrl = '0;
    ctrl.regDstSel = dstRt;
    ctrl.aluSrcA = srcPc;
    ctrl.aluSrcB = srcRegB;
    ctrl.aluOp = aluPassA;
    ctrl.pcSrc = pcAluResult;
    ctrl.excCause = causeQ;
    decodeStrobe = 1'b0;
    excTaken = 1'b0;
    phaseD = curPhase;
    stepD = stepQ + 1'b1;
    case (curPhase)
      phReset: begin
        phaseD = phFetch;
        stepD = '0;
      end
      phFetch: begin
        ctrl.aluSrcA = srcPc;  // PC + 4
        ctrl.aluSrcB = srcFour;
        ctrl.aluOp = aluAdd;
        ctrl.pcSrc = pcAluOut;
        case (stepQ)
          0: ctrl.aluOutWrite = 1'b1;
          2: ctrl.irWrite = 1'b1;
          `FETCH_STEPS - 1: begin
            decodeStrobe = 1'b1;
            ctrl.pcWrite = 1'b1;
            stepD = '0;
            case (info.instrClass)
              clsJump: begin
                ctrl.pcSrc = pcJumpTarget;
                phaseD = phFetch;
              end
              clsInvalid: phaseD = phFetch;  // Trap seen at next fetch
              default: phaseD = phExec;
            endcase
          end
          default: ;
        endcase
      end
      phExec: begin
        if (stepQ == '0) begin
          ctrl.regAWrite = 1'b1;
          ctrl.regBWrite = infoQ.readTwo;
        end else begin
          ctrl.aluSrcA = srcRegA;
          ctrl.aluSrcB = infoQ.immOp ? srcImm : srcRegB;
          ctrl.aluOp = infoQ.aluOp;
        end
        if (infoQ.instrClass == clsBranch) begin
          ctrl.pcSrc = pcAluOut;
          if (branchTaken) begin
            ctrl.aluSrcA = srcPc;  // Target is PC + offset
            ctrl.aluSrcB = srcImmShift;
            ctrl.aluOp = aluAdd;
          end
          if (stepQ == branchTestStep) begin
            if (branchCond) begin
              ctrl.aluOutWrite = 1'b1;
            end else begin
              phaseD = phFetch;
              stepD = '0;
            end
          end
          if (stepQ == branchPcStep) ctrl.pcWrite = 1'b1;
          if (stepQ == `BRANCH_TAKEN_STEPS - 1) begin
            phaseD = phFetch;
            stepD = '0;
          end
        end else begin
          ctrl.regDstSel = (infoQ.instrClass == clsAluReg) ? dstRd : dstRt;
          if (stepQ == 2) ctrl.regWrite = 1'b1;
          if (stepQ == `ALU_STEPS - 1) begin
            phaseD = phFetch;
            stepD = '0;
          end
        end
      end
      phExc: begin
        ctrl.aluSrcA = srcPc;  // EPC gets PC - 4
        ctrl.aluSrcB = srcFour;
        ctrl.aluOp = aluSub;
        ctrl.pcSrc = pcExcVector;
        case (stepQ)
          0: begin
            excTaken = 1'b1;
            ctrl.aluOutWrite = 1'b1;
            ctrl.excCause = excCause;
          end
          2: begin
            ctrl.pcWrite = 1'b1;
            ctrl.epcWrite = 1'b1;
          end
          `EXC_STEPS - 1: begin
            phaseD = phSettle;
            stepD = '0;
          end
          default: ;
        endcase
      end
      phSettle: begin
        if (stepQ == `SETTLE_STEPS - 1) begin  // Memory sees the new PC
          phaseD = phFetch;
          stepD = '0;
        end
      end
      default: begin
        phaseD = phFetch;
        stepD = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: sim/cpuCtrlTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpuCtrl_macros.svh"

module cpuCtrlTb import cpuCtrlPkg::*; ();

  localparam int numInstr = 300;
  localparam int cycleLimit = 6000;  // 300 worst case instructions of 17 cycles plus margin

  // What one instruction should show between its irWrite and the next one
  typedef struct packed {
    logic [4:0] spacing;
    logic       regWrite;
    aluOp_e     aluOp;
    regDst_e    regDst;
    aluSrcB_e   srcB;
    logic       regAWrite;
    logic       regBWrite;
    logic [1:0] aluOutWrites;
    logic [1:0] pcWrites;
    pcSrc_e     lastPcSrc;
    logic       exc;
    excCause_e  cause;
  } expect_t;

  // Kept instructions as {opcode, funct}
  localparam logic [11:0] instrPool [12] = '{
    {`OP_RTYPE, `FN_ADD}, {`OP_RTYPE, `FN_SUB}, {`OP_RTYPE, `FN_AND}, {`OP_RTYPE, `FN_SLT},
    {`OP_ADDI, 6'h00}, {`OP_ADDIU, 6'h00}, {`OP_SLTI, 6'h00},
    {`OP_BEQ, 6'h00}, {`OP_BNE, 6'h00}, {`OP_BLE, 6'h00}, {`OP_BGT, 6'h00},
    {`OP_J, 6'h00}
  };

  logic clk;
  logic reset_in;
  logic [5:0] opcode;
  logic [5:0] funct;
  logic branchCond;
  logic overflow;
  controlWord_t ctrl;

  expect_t expQ[$];
  int checkedCount = 0;
  int cycleCount = 0;
  int waitCycles;

  // Observed within the current irWrite window
  logic started = 1'b0;
  int spacing = 0;
  int pcWrites = 0;
  int regWrites = 0;
  int epcWrites = 0;
  int aluOutWrites = 0;
  int regAWrites = 0;
  int regBWrites = 0;
  pcSrc_e lastPcSrc;
  aluOp_e regAluOp;
  regDst_e regDst;
  aluSrcA_e regSrcA;
  aluSrcB_e regSrcB;
  excCause_e epcCause;

  cpuCtrlTop DUT (
    .clk        (clk),
    .reset_in   (reset_in),
    .opcode     (opcode),
    .funct      (funct),
    .branchCond (branchCond),
    .overflow   (overflow),
    .ctrl       (ctrl)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      $display("Test failed");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  function automatic logic [6:0] writeEnables(input controlWord_t c);
    return {c.pcWrite, c.epcWrite, c.irWrite, c.aluOutWrite,
            c.regAWrite, c.regBWrite, c.regWrite};
  endfunction

  function automatic expect_t expectedFor(input logic [5:0] opc, input logic [5:0] fn,
                                          input logic cond, input logic ovf);
    expect_t e;
    logic alu;
    logic ovfTrap;
    aluOp_e op;
    e = '0;
    alu = 1'b0;
    ovfTrap = ovf;
    op = aluPassA;
    e.regDst = dstRt;
    e.exc = 1'b1;  // Undefined code unless matched
    e.cause = excBadOpcode;
    e.pcWrites = 2'd2;
    e.lastPcSrc = pcExcVector;
    e.aluOutWrites = 2'd2;  // Exception entry and the next fetch
    e.spacing = 5'd12;
    case (opc)
      `OP_RTYPE: begin
        alu = 1'b1;
        e.regDst = dstRd;
        case (fn)
          `FN_ADD: op = aluAdd;
          `FN_SUB: op = aluSub;
          `FN_AND: op = aluAnd;
          `FN_SLT: op = aluSlt;
          default: alu = 1'b0;
        endcase
      end
      `OP_ADDI, `OP_ADDIU: begin
        alu = 1'b1;
        op = aluAdd;
        if (opc == `OP_ADDIU) ovfTrap = 1'b0;  // Overflow masked
      end
      `OP_SLTI: begin
        alu = 1'b1;
        op = aluSlt;
      end
      `OP_BEQ, `OP_BNE, `OP_BLE, `OP_BGT: begin
        e.exc = 1'b0;
        e.regAWrite = 1'b1;
        e.regBWrite = 1'b1;
        e.aluOutWrites = cond ? 2'd2 : 2'd1;
        e.lastPcSrc = pcAluOut;
        e.pcWrites = cond ? 2'd2 : 2'd1;
        e.spacing = cond ? 5'd13 : 5'd9;
      end
      `OP_J: begin
        e.exc = 1'b0;
        e.aluOutWrites = 2'd1;
        e.pcWrites = 2'd1;
        e.lastPcSrc = pcJumpTarget;
        e.spacing = 5'd5;
      end
      default: ;
    endcase
    if (alu) begin
      e.regWrite = 1'b1;
      e.aluOp = op;
      e.regAWrite = 1'b1;
      e.regBWrite = (opc == `OP_RTYPE);  // Immediate forms read rs only
      e.srcB = (opc == `OP_RTYPE) ? srcRegB : srcImm;
      e.exc = ovfTrap;
      e.cause = excOverflow;
      e.aluOutWrites = ovfTrap ? 2'd2 : 2'd1;
      e.pcWrites = ovfTrap ? 2'd2 : 2'd1;
      e.spacing = ovfTrap ? 5'd17 : 5'd10;
      if (!ovfTrap) e.lastPcSrc = pcAluOut;
    end
    return e;
  endfunction

  task automatic presentInstr();
    int pick;
    logic ovf;
    pick = $urandom_range(0, 13);
    if (pick < 12) begin
      {opcode, funct} = instrPool[pick];
    end else if (pick == 12) begin
      opcode = $urandom_range(6'h10, 6'h3F);  // Above every kept opcode
      funct = $urandom_range(0, 6'h3F);
    end else begin
      opcode = `OP_RTYPE;
      funct = $urandom_range(0, 6'h1F);  // Below every kept funct
    end
    branchCond = $urandom_range(0, 1);
    ovf = (pick inside {0, 1, 4, 5, 6}) && ($urandom_range(0, 2) == 0);
    expQ.push_back(expectedFor(opcode, funct, branchCond, ovf));
    if (ovf) begin
      repeat (3) @(posedge clk);  // Execute step 1
      #1 overflow = 1'b1;
      @(posedge clk);
      #1 overflow = 1'b0;
    end
  endtask

  task automatic compareWindow();
    expect_t e;
    checkValue("instruction queued for window", expQ.size() > 0, 1);
    e = expQ.pop_front();
    checkValue("irWrite spacing", spacing, e.spacing);
    checkValue("pcWrite count", pcWrites, e.pcWrites);
    checkValue("pcSrc at last pcWrite", lastPcSrc, e.lastPcSrc);
    checkValue("aluOutWrite count", aluOutWrites, e.aluOutWrites);
    checkValue("regAWrite count", regAWrites, e.regAWrite);
    checkValue("regBWrite count", regBWrites, e.regBWrite);
    checkValue("regWrite count", regWrites, e.regWrite);
    if (e.regWrite) begin
      checkValue("aluOp at regWrite", regAluOp, e.aluOp);
      checkValue("regDstSel at regWrite", regDst, e.regDst);
      checkValue("aluSrcA at regWrite", regSrcA, srcRegA);
      checkValue("aluSrcB at regWrite", regSrcB, e.srcB);
    end
    checkValue("epcWrite count", epcWrites, e.exc);
    if (e.exc) checkValue("exception cause", epcCause, e.cause);
    checkedCount++;
  endtask

  always @(negedge clk) begin
    if (!reset_in) begin
      spacing++;
      if (ctrl.pcWrite) begin
        pcWrites++;
        lastPcSrc = ctrl.pcSrc;
      end
      if (ctrl.aluOutWrite) aluOutWrites++;
      if (ctrl.regAWrite) regAWrites++;
      if (ctrl.regBWrite) regBWrites++;
      if (ctrl.regWrite) begin
        regWrites++;
        regAluOp = ctrl.aluOp;
        regDst = ctrl.regDstSel;
        regSrcA = ctrl.aluSrcA;
        regSrcB = ctrl.aluSrcB;
      end
      if (ctrl.epcWrite) begin
        epcWrites++;
        epcCause = ctrl.excCause;
      end
      if (ctrl.irWrite) begin
        if (started) compareWindow();
        started = 1'b1;  // New window opens
        spacing = 0;
        pcWrites = 0;
        aluOutWrites = 0;
        regAWrites = 0;
        regBWrites = 0;
        regWrites = 0;
        epcWrites = 0;
      end
    end
  end

  // Bound checker assertions
  always @(negedge clk) begin
    if (DUT.chk.failCount != 0) begin
      $display("Assertion in the bound checker failed before %0t", $time);
      $display("Test failed");
      $fatal(1, "Stopped at assertion failure");
    end
  end

  initial begin
    forever begin
      @(posedge clk);
      cycleCount++;
      if (cycleCount >= cycleLimit) begin
        $display("Timeout: run still going after %0d cycles", cycleLimit);
        $display("Test failed");
        $fatal(1, "Run stopped by cycle limit");
      end
    end
  end

  initial begin
    void'($urandom(98));
    reset_in = 1'b1;
    opcode = `OP_RTYPE;
    funct = `FN_ADD;
    branchCond = 1'b0;
    overflow = 1'b0;
    repeat (5) @(posedge clk);
    #1 reset_in = 1'b0;
    @(negedge clk);
    checkValue("write enables in reset cycle", writeEnables(ctrl), 0);
    waitCycles = 0;
    do begin
      @(negedge clk);
      waitCycles++;
    end while (!ctrl.irWrite);
    checkValue("cycles to first irWrite", waitCycles, 3);  // Fetch steps 0 to 2
    for (int i = 0; i < numInstr; i++) begin
      @(posedge clk);
      #1;
      presentInstr();
      do @(negedge clk); while (!ctrl.irWrite);
    end
    @(posedge clk);
    #1;
    checkValue("instructions checked", checkedCount, numInstr);
    checkValue("bound checker failures", DUT.chk.failCount, 0);
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/cpuCtrl_chk.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCtrlChk import cpuCtrlPkg::*; (
  input logic         clk,
  input logic         reset_in,
  input controlWord_t ctrl
);

  logic anyWrite;
  int failCount = 0;  // Assertion failures so far

  assign anyWrite = ctrl.pcWrite | ctrl.epcWrite | ctrl.irWrite | ctrl.aluOutWrite |
                    ctrl.regAWrite | ctrl.regBWrite | ctrl.regWrite;

  irSinglePulse: assert property (@(posedge clk) disable iff (reset_in)
    ctrl.irWrite |=> !ctrl.irWrite)
    else begin
      failCount++;
      $error("irWrite high for two cycles in a row");
    end

  pcSinglePulse: assert property (@(posedge clk) disable iff (reset_in)
    ctrl.pcWrite |=> !ctrl.pcWrite)
    else begin
      failCount++;
      $error("pcWrite high for two cycles in a row");
    end

  // EPC is only saved on the way to the vector
  epcWithVector: assert property (@(posedge clk) disable iff (reset_in)
    ctrl.epcWrite |-> (ctrl.pcWrite && ctrl.pcSrc == pcExcVector))
    else begin
      failCount++;
      $error("epcWrite without pcWrite to the exception vector");
    end

  quietAfterReset: assert property (@(posedge clk)
    $fell(reset_in) |-> !anyWrite)
    else begin
      failCount++;
      $error("Write enable high in the cycle after reset");
    end

endmodule

bind cpuCtrlTop cpuCtrlChk chk (
  .clk      (clk),
  .reset_in (reset_in),
  .ctrl     (ctrl)
);

`default_nettype wire
